//--- rtl/pong_config.svh
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

`define COORD_BITS 12

// Playfield
`define FRAME_WIDTH      12'd640
`define FRAME_HEIGHT     12'd480
`define HALF_FRAME_WIDTH 12'd320

// Paddles, x positions give the left column
`define PLAYER_WIDTH         12'd10
`define PLAYER_HEIGHT        12'd80
`define HALF_PLAYER_HEIGHT   12'd40
`define PLAYER_1_X_POS       12'd20
`define PLAYER_2_X_POS       12'd610
`define DEFAULT_PLAYER_SPEED 12'd4
`define INITIAL_PLAYER_Y_POS 12'd200   // Ball centre lands in the middle zone

// Ball
`define BALL_SIZE          12'd8
`define BALL_CENTER_OFFSET 12'd4
`define COLLISION_OFFSET   12'd4
`define SERVE_X_STEP       3'd4
`define INITIAL_BALL_X_POS 12'd316
`define INITIAL_BALL_Y_POS 12'd236

// Hit zones, measured from the paddle top
`define CORNER_HIT_ZONE_SIZE 12'd8
`define HIT_ZONE_1           12'd0
`define HIT_ZONE_2           12'd24
`define HIT_ZONE_3           12'd34
`define HIT_ZONE_4           12'd46
`define HIT_ZONE_5           12'd56
`define HIT_ZONE_MAX         12'd80

// Colours, one bit per RGB channel
`define BALL_COLOR     3'b111
`define PLAYER_1_COLOR 3'b001
`define PLAYER_2_COLOR 3'b100
`define BORDER_COLOR   3'b010

`define WIN_SCORE 3'd7

`endif

//--- rtl/pong_geom_pkg.sv
`include "pong_config.svh"

package pong_geom_pkg;

    // One screen axis, x or y
    typedef logic [`COORD_BITS-1:0] coord_t;

    // Pixel colour as {R, G, B}
    typedef logic [2:0] color_t;

endpackage

//--- rtl/pong_play_pkg.sv
package pong_play_pkg;

    // Key codes coming from the keypads
    typedef enum logic [3:0] {
        KEY_IDLE = 4'd0,
        KEY_UP   = 4'd2,
        KEY_DOWN = 4'd8
    } key_dir_t;

    // Ball step per tick on one axis
    typedef logic [2:0] speed_t;

    // One row of the paddle hit-zone table
    typedef struct packed {
        speed_t x_step;
        speed_t y_step;
        logic   y_up;       // New vertical direction
        logic   y_change;   // Middle zone keeps the old direction
    } bounce_t;

    // Points of one player
    typedef logic [2:0] score_t;

endpackage

//--- rtl/match_control.sv
module match_control (
    input  logic BALL_CLOCK,
    input  logic reset,
    input  logic pause_key,
    input  logic restart_key,
    input  logic win_event,
    output logic paused,
    output logic game_restart
);

    logic pause_key_q;
    logic restart_key_q;
    logic pause_press;
    logic restart_press;

    // Rising edges of the button levels
    assign pause_press   = pause_key & ~pause_key_q;
    assign restart_press = restart_key & ~restart_key_q;

    always_ff @(posedge BALL_CLOCK) begin
        if (reset) begin
            pause_key_q   <= 1'b0;
            restart_key_q <= 1'b0;
            paused        <= 1'b1;   // Game starts halted
            game_restart  <= 1'b0;
        end else begin
            pause_key_q   <= pause_key;
            restart_key_q <= restart_key;
            game_restart  <= 1'b0;

            if (restart_press || win_event) begin
                paused       <= 1'b1;
                game_restart <= 1'b1;
            end else if (pause_press) begin
                paused <= ~paused;
            end
        end
    end

endmodule

//--- rtl/paddle_mover.sv
`include "pong_config.svh"

module paddle_mover
    import pong_geom_pkg::*, pong_play_pkg::*;
(
    input  logic     BALL_CLOCK,
    input  logic     reset,
    input  logic     tick,
    input  logic     paused,
    input  logic     game_restart,
    input  key_dir_t keys,
    output coord_t   paddle_y
);

    logic at_top;
    logic at_bottom;

    // Next step would leave the frame
    assign at_top    = paddle_y <= `DEFAULT_PLAYER_SPEED;
    assign at_bottom = (paddle_y + `PLAYER_HEIGHT + `DEFAULT_PLAYER_SPEED) >= `FRAME_HEIGHT;

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || game_restart) begin
            paddle_y <= `INITIAL_PLAYER_Y_POS;
        end else if (tick && !paused) begin
            case (keys)
                KEY_UP: begin
                    if (at_top) begin
                        paddle_y <= 12'd1;
                    end else begin
                        paddle_y <= paddle_y - `DEFAULT_PLAYER_SPEED;
                    end
                end
                KEY_DOWN: begin
                    if (at_bottom) begin
                        paddle_y <= `FRAME_HEIGHT - `PLAYER_HEIGHT - 12'd1;
                    end else begin
                        paddle_y <= paddle_y + `DEFAULT_PLAYER_SPEED;
                    end
                end
                default: paddle_y <= paddle_y;   // Idle or unknown code
            endcase
        end
    end

endmodule

//--- rtl/ball_engine.sv
`include "pong_config.svh"

module ball_engine
    import pong_geom_pkg::*, pong_play_pkg::*;
(
    input  logic   BALL_CLOCK,
    input  logic   reset,
    input  logic   tick,
    input  logic   paused,
    input  logic   game_restart,
    input  coord_t paddle_1_y,
    input  coord_t paddle_2_y,
    output coord_t ball_x,
    output coord_t ball_y,
    output score_t score_1,
    output score_t score_2,
    output color_t winner,
    output logic   win_event
);

    logic    ball_left;        // Heading towards player 1
    logic    ball_up;
    speed_t  step_x;
    speed_t  step_y;
    logic    miss;             // Ball passed a paddle, waiting for the side edge
    coord_t  step_x_c;
    coord_t  step_y_c;
    coord_t  center_y;
    coord_t  side_paddle_y;
    coord_t  rel_y;
    logic    at_left;
    logic    at_right;
    logic    at_paddle;
    logic    zone_hit;
    logic    wall_top;
    logic    wall_bottom;
    logic    at_edge;
    logic    left_next;
    logic    up_next;
    logic    opp_at_win;
    bounce_t bounce;

    // rel is the ball centre below (paddle top - corner size)
    function automatic bounce_t zone_bounce(input coord_t rel);
        bounce_t b;
        b = '{x_step: 3'd4, y_step: 3'd0, y_up: 1'b0, y_change: 1'b0};
        if (rel < `CORNER_HIT_ZONE_SIZE + `HIT_ZONE_1) begin
            b = '{x_step: 3'd1, y_step: 3'd3, y_up: 1'b1, y_change: 1'b1};
        end else if (rel < `CORNER_HIT_ZONE_SIZE + `HIT_ZONE_2) begin
            b = '{x_step: 3'd2, y_step: 3'd2, y_up: 1'b1, y_change: 1'b1};
        end else if (rel < `CORNER_HIT_ZONE_SIZE + `HIT_ZONE_3) begin
            b = '{x_step: 3'd3, y_step: 3'd1, y_up: 1'b1, y_change: 1'b1};
        end else if (rel < `CORNER_HIT_ZONE_SIZE + `HIT_ZONE_4) begin
            b = '{x_step: 3'd4, y_step: 3'd0, y_up: 1'b0, y_change: 1'b0};
        end else if (rel < `CORNER_HIT_ZONE_SIZE + `HIT_ZONE_5) begin
            b = '{x_step: 3'd3, y_step: 3'd1, y_up: 1'b0, y_change: 1'b1};
        end else if (rel < `CORNER_HIT_ZONE_SIZE + `HIT_ZONE_MAX) begin
            b = '{x_step: 3'd2, y_step: 3'd2, y_up: 1'b0, y_change: 1'b1};
        end else begin
            b = '{x_step: 3'd1, y_step: 3'd3, y_up: 1'b0, y_change: 1'b1};
        end
        return b;
    endfunction

    assign step_x_c = {{(`COORD_BITS - $bits(speed_t)){1'b0}}, step_x};
    assign step_y_c = {{(`COORD_BITS - $bits(speed_t)){1'b0}}, step_y};
    assign center_y = ball_y + `BALL_CENTER_OFFSET;

    // Contact windows, one step wide, in front of each paddle face
    assign at_left  = ball_left &&
                      ball_x >= (`PLAYER_1_X_POS + `PLAYER_WIDTH) &&
                      ball_x <= (`PLAYER_1_X_POS + `PLAYER_WIDTH + step_x_c);
    assign at_right = !ball_left &&
                      (ball_x + `BALL_SIZE) >= (`PLAYER_2_X_POS - step_x_c) &&
                      (ball_x + `BALL_SIZE) <= `PLAYER_2_X_POS;
    assign at_paddle = !miss && (at_left || at_right);

    // Wraps to a large value when the ball is far above the paddle
    assign side_paddle_y = at_left ? paddle_1_y : paddle_2_y;
    assign rel_y    = center_y + `CORNER_HIT_ZONE_SIZE - side_paddle_y;
    assign zone_hit = rel_y < (`HIT_ZONE_MAX + `CORNER_HIT_ZONE_SIZE + `CORNER_HIT_ZONE_SIZE);
    assign bounce   = zone_bounce(rel_y);

    assign wall_top    = ball_y <= `COLLISION_OFFSET;
    assign wall_bottom = (ball_y + `BALL_SIZE) >= (`FRAME_HEIGHT - `COLLISION_OFFSET);
    assign at_edge     = ball_x <= (`COLLISION_OFFSET + 12'd1) ||
                         ball_x >= (`FRAME_WIDTH - `BALL_SIZE);

    // Walls win over the paddle for the vertical direction
    assign left_next = (at_paddle && zone_hit) ? at_right : ball_left;
    assign up_next   = wall_top ? 1'b0 :
                       wall_bottom ? 1'b1 :
                       (at_paddle && zone_hit && bounce.y_change) ? bounce.y_up : ball_up;

    assign opp_at_win = (at_left ? score_2 : score_1) == `WIN_SCORE;

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || game_restart) begin
            ball_x    <= `INITIAL_BALL_X_POS;
            ball_y    <= `INITIAL_BALL_Y_POS;
            ball_left <= 1'b0;
            ball_up   <= 1'b0;
            step_x    <= `SERVE_X_STEP;
            step_y    <= 3'd0;
            miss      <= 1'b0;
            score_1   <= '0;
            score_2   <= '0;
            win_event <= 1'b0;
            if (reset) begin
                winner <= '0;   // A restart keeps the last winner on show
            end
        end else begin
            win_event <= 1'b0;
            if (tick && !paused) begin
                if (!miss) begin
                    winner <= '0;
                end
                ball_x    <= left_next ? ball_x - step_x_c : ball_x + step_x_c;
                ball_y    <= up_next ? ball_y - step_y_c : ball_y + step_y_c;
                ball_left <= left_next;
                ball_up   <= up_next;

                if (miss) begin
                    if (at_edge) begin
                        // Serve again from the centre, level with the losing paddle
                        ball_x <= `INITIAL_BALL_X_POS;
                        ball_y <= ((ball_x < `HALF_FRAME_WIDTH) ? paddle_1_y : paddle_2_y)
                                  + `HALF_PLAYER_HEIGHT - `BALL_CENTER_OFFSET;
                        step_x <= `SERVE_X_STEP;
                        step_y <= 3'd0;
                        miss   <= 1'b0;
                    end
                end else if (at_paddle) begin
                    if (zone_hit) begin
                        step_x <= bounce.x_step;
                        step_y <= bounce.y_step;
                    end else begin
                        miss <= 1'b1;
                        if (opp_at_win) begin
                            score_1   <= '0;
                            score_2   <= '0;
                            winner    <= at_left ? `PLAYER_2_COLOR : `PLAYER_1_COLOR;
                            win_event <= 1'b1;
                        end else if (at_left) begin
                            score_2 <= score_2 + 3'd1;   // Player 1 missed
                        end else begin
                            score_1 <= score_1 + 3'd1;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- rtl/pixel_renderer.sv
`include "pong_config.svh"

module pixel_renderer
    import pong_geom_pkg::*;
(
    input  logic   BALL_CLOCK,
    input  logic   reset,
    input  coord_t pixel_x,
    input  coord_t pixel_y,
    input  logic   pixel_valid,
    input  coord_t ball_x,
    input  coord_t ball_y,
    input  coord_t paddle_1_y,
    input  coord_t paddle_2_y,
    input  logic   color_ready,
    output logic   pixel_ready,
    output color_t color,
    output logic   color_valid
);

    logic   hit_ball;
    logic   hit_player_1;
    logic   hit_player_2;
    logic   hit_border;
    logic   s1_valid;
    logic   s1_ball;
    logic   s1_player_1;
    logic   s1_player_2;
    logic   s1_border;
    logic   s1_ready;
    logic   s2_valid;
    logic   s2_ready;
    color_t s2_color;
    color_t pick_color;

    // A stage accepts when empty or when its content moves on
    assign s2_ready    = !s2_valid || color_ready;
    assign s1_ready    = !s1_valid || s2_ready;
    assign pixel_ready = s1_ready;
    assign color       = s2_color;
    assign color_valid = s2_valid;

    // All ranges include their far edge
    assign hit_ball     = pixel_x >= ball_x && pixel_x <= (ball_x + `BALL_SIZE) &&
                          pixel_y >= ball_y && pixel_y <= (ball_y + `BALL_SIZE);
    assign hit_player_1 = pixel_x >= `PLAYER_1_X_POS &&
                          pixel_x <= (`PLAYER_1_X_POS + `PLAYER_WIDTH) &&
                          pixel_y >= paddle_1_y && pixel_y <= (paddle_1_y + `PLAYER_HEIGHT);
    assign hit_player_2 = pixel_x >= `PLAYER_2_X_POS &&
                          pixel_x <= (`PLAYER_2_X_POS + `PLAYER_WIDTH) &&
                          pixel_y >= paddle_2_y && pixel_y <= (paddle_2_y + `PLAYER_HEIGHT);
    assign hit_border   = pixel_x == 12'd1 || pixel_x == `FRAME_WIDTH ||
                          pixel_y == 12'd1 || pixel_y == `FRAME_HEIGHT;

    // Ball over paddles over border
    always_comb begin
        if (s1_ball) begin
            pick_color = `BALL_COLOR;
        end else if (s1_player_1) begin
            pick_color = `PLAYER_1_COLOR;
        end else if (s1_player_2) begin
            pick_color = `PLAYER_2_COLOR;
        end else if (s1_border) begin
            pick_color = `BORDER_COLOR;
        end else begin
            pick_color = 3'b000;
        end
    end

    always_ff @(posedge BALL_CLOCK) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= pixel_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge BALL_CLOCK) begin
        if (s1_ready) begin
            s1_ball     <= hit_ball;
            s1_player_1 <= hit_player_1;
            s1_player_2 <= hit_player_2;
            s1_border   <= hit_border;
        end
        if (s2_ready) begin
            s2_color <= pick_color;   // Held while the consumer stalls
        end
    end

endmodule

//--- rtl/pong_top.sv
module pong_top
    import pong_geom_pkg::*, pong_play_pkg::*;
(
    input  logic     BALL_CLOCK,
    input  logic     reset,
    input  logic     tick,
    input  logic     pause_key,
    input  logic     restart_key,
    input  key_dir_t keys_1,
    input  key_dir_t keys_2,
    input  coord_t   pixel_x,
    input  coord_t   pixel_y,
    input  logic     pixel_valid,
    output logic     pixel_ready,
    output color_t   color,
    output logic     color_valid,
    input  logic     color_ready,
    output score_t   score_1,
    output score_t   score_2,
    output color_t   winner,
    output logic     paused
);

    logic   game_restart;
    logic   win_event;
    coord_t paddle_1_y;
    coord_t paddle_2_y;
    coord_t ball_x;
    coord_t ball_y;

    match_control u_match_control (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .pause_key    (pause_key),
        .restart_key  (restart_key),
        .win_event    (win_event),
        .paused       (paused),
        .game_restart (game_restart)
    );

    paddle_mover player_1_mover (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .tick         (tick),
        .paused       (paused),
        .game_restart (game_restart),
        .keys         (keys_1),
        .paddle_y     (paddle_1_y)
    );

    paddle_mover player_2_mover (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .tick         (tick),
        .paused       (paused),
        .game_restart (game_restart),
        .keys         (keys_2),
        .paddle_y     (paddle_2_y)
    );

    ball_engine u_ball_engine (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .tick         (tick),
        .paused       (paused),
        .game_restart (game_restart),
        .paddle_1_y   (paddle_1_y),
        .paddle_2_y   (paddle_2_y),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .score_1      (score_1),
        .score_2      (score_2),
        .winner       (winner),
        .win_event    (win_event)
    );

    pixel_renderer u_pixel_renderer (
        .BALL_CLOCK  (BALL_CLOCK),
        .reset       (reset),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_valid (pixel_valid),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .paddle_1_y  (paddle_1_y),
        .paddle_2_y  (paddle_2_y),
        .color_ready (color_ready),
        .pixel_ready (pixel_ready),
        .color       (color),
        .color_valid (color_valid)
    );

endmodule

//--- testbench/pong_sva.sv
`include "pong_config.svh"

module pong_sva (
    input logic       BALL_CLOCK,
    input logic       reset,
    input logic [2:0] color,
    input logic       color_valid,
    input logic       color_ready,
    input logic [2:0] score_1,
    input logic [2:0] score_2,
    input logic       paused,
    input logic       game_restart,
    input logic       win_event
);
    timeunit 1ns;
    timeprecision 100ps;

    // Output stage holds its answer under back-pressure
    color_held: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        color_valid && !color_ready |=> color_valid && $stable(color))
        else $error("color changed or dropped while color_ready was low");

    score_limit: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        score_1 <= `WIN_SCORE && score_2 <= `WIN_SCORE)
        else $error("score above the winning score");

    restart_pulse: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        game_restart |=> !game_restart)
        else $error("game_restart lasted more than one cycle");

    pause_on_win: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        win_event |=> paused)
        else $error("game still running after a win");

endmodule

bind pong_top pong_sva u_pong_sva (
    .BALL_CLOCK   (BALL_CLOCK),
    .reset        (reset),
    .color        (color),
    .color_valid  (color_valid),
    .color_ready  (color_ready),
    .score_1      (score_1),
    .score_2      (score_2),
    .paused       (paused),
    .game_restart (game_restart),
    .win_event    (win_event)
);

//--- testbench/pong_tb.sv
`include "pong_config.svh"

module pong_tb
    import pong_geom_pkg::*, pong_play_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic     BALL_CLOCK;
    logic     reset;
    logic     tick;
    logic     pause_key;
    logic     restart_key;
    key_dir_t keys_1;
    key_dir_t keys_2;
    coord_t   pixel_x;
    coord_t   pixel_y;
    logic     pixel_valid;
    logic     pixel_ready;
    color_t   color;
    logic     color_valid;
    logic     color_ready;
    score_t   score_1;
    score_t   score_2;
    color_t   winner;
    logic     paused;

    int error_count;
    int timeout_count;

    pong_top DUT (.*);

    initial begin
        BALL_CLOCK = 1'b0;
        forever #2 BALL_CLOCK = ~BALL_CLOCK;
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("FAIL @%0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeout_count++;
        $display("Timed out while waiting for %s at %0t", msg, $time);
    endtask

    // Colour of a pixel from the drawing priority rule
    function automatic color_t expected_color(input coord_t x, input coord_t y,
                                              input coord_t bx, input coord_t by,
                                              input coord_t p1, input coord_t p2);
        if (x >= bx && x <= bx + `BALL_SIZE && y >= by && y <= by + `BALL_SIZE)
            return `BALL_COLOR;
        if (x >= `PLAYER_1_X_POS && x <= `PLAYER_1_X_POS + `PLAYER_WIDTH &&
            y >= p1 && y <= p1 + `PLAYER_HEIGHT)
            return `PLAYER_1_COLOR;
        if (x >= `PLAYER_2_X_POS && x <= `PLAYER_2_X_POS + `PLAYER_WIDTH &&
            y >= p2 && y <= p2 + `PLAYER_HEIGHT)
            return `PLAYER_2_COLOR;
        if (x == 1 || x == `FRAME_WIDTH || y == 1 || y == `FRAME_HEIGHT)
            return `BORDER_COLOR;
        return 3'b000;
    endfunction

    task automatic pulse_tick();
        @(negedge BALL_CLOCK);
        tick = 1'b1;
        @(negedge BALL_CLOCK);
        tick = 1'b0;
    endtask

    task automatic press_button(input bit restart);
        @(negedge BALL_CLOCK);
        if (restart) restart_key = 1'b1;
        else pause_key = 1'b1;
        @(negedge BALL_CLOCK);
        restart_key = 1'b0;
        pause_key   = 1'b0;
    endtask

    task automatic query_pixel(input coord_t x, input coord_t y, output color_t c);
        int n;
        c = 3'b000;
        @(negedge BALL_CLOCK);
        pixel_x     = x;
        pixel_y     = y;
        pixel_valid = 1'b1;
        n = 0;
        while (!pixel_ready && n < 100) begin
            @(negedge BALL_CLOCK);
            n++;
        end
        if (!pixel_ready) begin
            report_timeout("pixel_ready");
            pixel_valid = 1'b0;
            return;
        end
        @(negedge BALL_CLOCK);   // Accepted on the edge in between
        pixel_valid = 1'b0;
        n = 0;
        while (!color_valid && n < 100) begin
            @(negedge BALL_CLOCK);
            n++;
        end
        if (!color_valid) report_timeout("color_valid");
        c = color;
    endtask

    task automatic check_pixel(input coord_t x, input coord_t y, input color_t exp);
        color_t c;
        query_pixel(x, y, c);
        if (c !== exp)
            report_error($sformatf("pixel (%0d,%0d) is %b, expected %b", x, y, c, exp));
    endtask

    task automatic test_after_reset();
        if (paused !== 1'b1) report_error("paused not set after reset");
        if (score_1 !== 0 || score_2 !== 0) report_error("scores not 0 after reset");
        if (winner !== 0) report_error("winner not 0 after reset");
        check_pixel(`INITIAL_BALL_X_POS, `INITIAL_BALL_Y_POS, `BALL_COLOR);
        check_pixel(12'd1, 12'd200, `BORDER_COLOR);
        check_pixel(12'd100, 12'd100, 3'b000);
        repeat (5) pulse_tick();   // Paused, nothing moves
        check_pixel(`INITIAL_BALL_X_POS, `INITIAL_BALL_Y_POS, `BALL_COLOR);
    endtask

    task automatic wait_paused(input logic exp);
        int n;
        n = 0;
        while (paused !== exp && n < 20) begin
            @(negedge BALL_CLOCK);
            n++;
        end
        if (paused !== exp) report_error($sformatf("paused is %b, expected %b", paused, exp));
    endtask

    task automatic test_pause_toggle();
        press_button(1'b0);
        wait_paused(1'b0);
        press_button(1'b0);
        wait_paused(1'b1);
    endtask

    task automatic test_paddle_move();
        coord_t top;
        press_button(1'b0);
        wait_paused(1'b0);
        top = `INITIAL_PLAYER_Y_POS;
        keys_1 = KEY_UP;
        repeat (10) begin
            pulse_tick();
            top = (top > `DEFAULT_PLAYER_SPEED + 1) ? top - `DEFAULT_PLAYER_SPEED : 12'd1;
        end
        check_pixel(`PLAYER_1_X_POS + 12'd5, top + 12'd1, `PLAYER_1_COLOR);
        check_pixel(`PLAYER_1_X_POS + 12'd5, top - 12'd1, 3'b000);
        repeat (50) begin
            pulse_tick();
            top = (top > `DEFAULT_PLAYER_SPEED + 1) ? top - `DEFAULT_PLAYER_SPEED : 12'd1;
        end
        keys_1 = KEY_IDLE;
        check_pixel(`PLAYER_1_X_POS + 12'd5, top + 12'd1, `PLAYER_1_COLOR);
        check_pixel(`PLAYER_1_X_POS + 12'd5, top - 12'd1, 3'b000);
    endtask

    task automatic test_first_score();
        int n;
        n = 0;
        while (score_1 == 0 && score_2 == 0 && n < 1000) begin
            pulse_tick();
            n++;
        end
        if (score_1 == 0 && score_2 == 0) begin
            report_timeout("the first score");
        end else if (score_2 !== 1 || score_1 !== 0) begin
            report_error($sformatf("first score %0d:%0d, expected 0:1", score_1, score_2));
        end
    endtask

    task automatic test_win_restart();
        int n;
        n = 0;
        while (winner == 0 && n < 20000) begin
            pulse_tick();
            n++;
        end
        if (winner == 0) begin
            report_timeout("a winner");
            return;
        end
        if (winner !== `PLAYER_2_COLOR) report_error("winner is not player 2");
        if (score_1 !== 0 || score_2 !== 0) report_error("scores not cleared on win");
        wait_paused(1'b1);   // Pause follows the win pulse by one edge
        press_button(1'b1);
        repeat (3) @(negedge BALL_CLOCK);
        if (score_1 !== 0 || score_2 !== 0) report_error("scores not 0 after restart");
        if (paused !== 1'b1) report_error("game not paused after restart");
    endtask

    task automatic test_back_pressure();
        coord_t qx [5];
        coord_t qy [5];
        color_t exp;
        int     sent;
        int     got;
        int     n;
        logic   acc;
        logic   v;
        color_t c;
        qx = '{12'd320, 12'd25, 12'd615, 12'd640, 12'd100};
        qy = '{12'd240, 12'd250, 12'd210, 12'd100, 12'd100};
        sent = 0;
        got  = 0;
        @(negedge BALL_CLOCK);
        color_ready = 1'b0;
        pixel_x     = qx[0];
        pixel_y     = qy[0];
        pixel_valid = 1'b1;
        n = 0;
        while (pixel_ready && n < 20) begin
            acc = pixel_valid && pixel_ready;
            @(negedge BALL_CLOCK);
            n++;
            if (acc) begin
                sent++;
                pixel_x = qx[sent];
                pixel_y = qy[sent];
            end
        end
        if (pixel_ready) report_timeout("pixel_ready to fall");
        if (sent != 2) report_error($sformatf("%0d queries in flight, expected 2", sent));
        color_ready = 1'b1;
        n = 0;
        while (got < 5 && n < 100) begin
            #1;   // Sample in the low phase, after ready has settled
            acc = pixel_valid && pixel_ready;
            v   = color_valid;
            c   = color;
            @(negedge BALL_CLOCK);
            n++;
            if (v) begin
                exp = expected_color(qx[got], qy[got], `INITIAL_BALL_X_POS,
                                     `INITIAL_BALL_Y_POS, `INITIAL_PLAYER_Y_POS,
                                     `INITIAL_PLAYER_Y_POS);
                if (c !== exp)
                    report_error($sformatf("answer %0d is %b, expected %b", got, c, exp));
                got++;
            end
            if (acc) begin
                sent++;
                if (sent < 5) begin
                    pixel_x = qx[sent];
                    pixel_y = qy[sent];
                end else begin
                    pixel_valid = 1'b0;
                end
            end
        end
        if (got < 5) report_timeout("the stalled answers");
        pixel_valid = 1'b0;
    endtask

    initial begin
        error_count   = 0;
        timeout_count = 0;
        reset         = 1'b1;
        tick          = 1'b0;
        pause_key     = 1'b0;
        restart_key   = 1'b0;
        keys_1        = KEY_IDLE;
        keys_2        = KEY_IDLE;
        pixel_x       = '0;
        pixel_y       = '0;
        pixel_valid   = 1'b0;
        color_ready   = 1'b1;
        repeat (16) @(posedge BALL_CLOCK);
        @(negedge BALL_CLOCK);
        reset = 1'b0;

        test_after_reset();
        test_pause_toggle();
        test_paddle_move();
        test_first_score();
        test_win_restart();
        test_back_pressure();

        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- pong.f
+incdir+rtl
rtl/pong_geom_pkg.sv
rtl/pong_play_pkg.sv
rtl/match_control.sv
rtl/paddle_mover.sv
rtl/ball_engine.sv
rtl/pixel_renderer.sv
rtl/pong_top.sv
testbench/pong_sva.sv
testbench/pong_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pong_tb
FILELIST  ?= pong.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
